/* s2mm_defines.svh */
`ifndef S2MM_DEFINES_SVH
`define S2MM_DEFINES_SVH

////////////////////
// Stream side

// Width of one pixel on s_axis_tdata
`define S2MM_PIXEL_W 8

// Image width and height counters
`define S2MM_IMG_BITS 12

////////////////////
// Memory side

// AXI4 write data and address widths
`define S2MM_DATA_W 32
`define S2MM_ADDR_W 32

// Pixels carried by one data beat
`define S2MM_PIX_PER_WORD 4

// Beats per INCR burst
`define S2MM_BURST_LEN 16

////////////////////
// Pixel FIFO

// Depth in pixels, so 64 words
`define S2MM_FIFO_DEPTH 256

// Whole-word count, 0 to 64
`define S2MM_CNT_BITS 7

`endif

/* s2mm_pkg.sv */
`default_nettype none

`include "s2mm_defines.svh"

package s2mm_pkg;

	// Frame writer sequencing
	typedef enum logic [2:0] {
		WR_IDLE,
		WR_SYNC,
		WR_ADDR,
		WR_DATA,
		WR_RESP,
		WR_FLUSH
	} wr_state_e;

	// What the pixel FIFO does in a cycle
	typedef enum logic [2:0] {
		OP_NONE,
		OP_PUSH,
		OP_POP,
		OP_PUSH_POP,
		OP_FLUSH
	} fifo_op_e;

	typedef logic [`S2MM_PIXEL_W-1:0] pixel_t;

	// Same bit order as {tlast, tuser, tdata}
	typedef struct packed {
		logic   eol;
		logic   sof;
		pixel_t pix;
	} tagged_pixel_t;

	typedef tagged_pixel_t [`S2MM_PIX_PER_WORD-1:0] packed_word_t;

	typedef logic [`S2MM_DATA_W-1:0] axi_data_t;
	typedef logic [`S2MM_ADDR_W-1:0] axi_addr_t;

	typedef logic [$clog2(`S2MM_BURST_LEN)-1:0] beat_cnt_t;
	typedef logic [2*`S2MM_IMG_BITS-$clog2(`S2MM_PIX_PER_WORD)-1:0] frame_cnt_t;

endpackage

`default_nettype wire

/* s2mm_ifs.sv */
`default_nettype none

`include "s2mm_defines.svh"

////////////////////
// FIFO read side, first-word-fall-through
interface fifo_rd_if;
	s2mm_pkg::packed_word_t rd_data;
	logic empty;
	logic rd_en;
	logic [`S2MM_CNT_BITS-1:0] rd_data_count;
	logic flush;

	modport fifo (output rd_data, output empty, output rd_data_count,
		input rd_en, input flush);

	modport reader (input rd_data, input empty, input rd_data_count,
		output rd_en, output flush);
endinterface

////////////////////
// AXI4 write channels, no read side
interface axi_wr_if;
	s2mm_pkg::axi_addr_t awaddr;
	logic [7:0] awlen;
	logic [2:0] awsize;
	logic [1:0] awburst;
	logic awlock;
	logic [3:0] awcache;
	logic [2:0] awprot;
	logic [3:0] awqos;
	logic awvalid;
	logic awready;
	s2mm_pkg::axi_data_t wdata;
	logic [`S2MM_DATA_W/8-1:0] wstrb;
	logic wlast;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;

	modport master (output awaddr, output awlen, output awsize, output awburst,
		output awlock, output awcache, output awprot, output awqos, output awvalid,
		input awready, output wdata, output wstrb, output wlast, output wvalid,
		input wready, input bvalid, output bready);
endinterface

`default_nettype wire

/* pixel_fifo.sv */
`default_nettype none

`include "s2mm_defines.svh"

module pixel_fifo
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    wr_en,
	input  s2mm_pkg::tagged_pixel_t wr_data,
	output logic                    full,
	fifo_rd_if.fifo                 rd
);
	localparam int PTR_W = $clog2(`S2MM_FIFO_DEPTH);
	localparam int LANES = `S2MM_PIX_PER_WORD;
	localparam int LANE_W = $clog2(`S2MM_PIX_PER_WORD);
	localparam int WPTR_W = PTR_W - LANE_W;

	s2mm_pkg::tagged_pixel_t mem [`S2MM_FIFO_DEPTH];

	logic [PTR_W-1:0]  wr_ptr;
	logic [WPTR_W-1:0] rd_ptr;
	logic [PTR_W:0]    pix_cnt;
	s2mm_pkg::fifo_op_e op;

	// Flush beats any push or pop in the same cycle
	always_comb
	begin
		if (rd.flush)
			op = s2mm_pkg::OP_FLUSH;
		else
		begin
			case ({wr_en, rd.rd_en})
				2'b10: op = s2mm_pkg::OP_PUSH;
				2'b01: op = s2mm_pkg::OP_POP;
				2'b11: op = s2mm_pkg::OP_PUSH_POP;
				default: op = s2mm_pkg::OP_NONE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en && op != s2mm_pkg::OP_FLUSH)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			pix_cnt <= '0;
		end
		else
		begin
			case (op)
				s2mm_pkg::OP_PUSH:
				begin
					wr_ptr  <= wr_ptr + 1'b1;
					pix_cnt <= pix_cnt + 1'b1;
				end
				s2mm_pkg::OP_POP:
				begin
					rd_ptr  <= rd_ptr + 1'b1;
					pix_cnt <= pix_cnt - (PTR_W+1)'(LANES);
				end
				s2mm_pkg::OP_PUSH_POP:
				begin
					wr_ptr  <= wr_ptr + 1'b1;
					rd_ptr  <= rd_ptr + 1'b1;
					pix_cnt <= pix_cnt - (PTR_W+1)'(LANES - 1);
				end
				s2mm_pkg::OP_FLUSH:
				begin
					wr_ptr  <= '0;
					rd_ptr  <= '0;
					pix_cnt <= '0;
				end
				default: ;
			endcase
		end
	end

	assign full = (pix_cnt == (PTR_W+1)'(`S2MM_FIFO_DEPTH));

	// Only complete words are visible to the reader
	assign rd.rd_data_count = pix_cnt[PTR_W:LANE_W];
	assign rd.empty = (rd.rd_data_count == '0);

	// Oldest pixel of the word sits in the top lane
	always_comb
	begin
		for (int k = 0; k < LANES; k++)
			rd.rd_data[LANES-1-k] = mem[{rd_ptr, LANE_W'(k)}];
	end

	a_no_write_full: assert property (@(posedge clk) disable iff (rst) !(wr_en && full))
		else $error("pixel written while FIFO full");

	a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
		!(rd.rd_en && rd.empty))
		else $error("word popped while FIFO empty");

endmodule

`default_nettype wire

/* burst_counter.sv */
`default_nettype none

`include "s2mm_defines.svh"

module burst_counter
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 frame_start,
	input  logic                 beat,
	input  logic                 burst_done,
	input  s2mm_pkg::axi_addr_t  base_addr,
	input  s2mm_pkg::frame_cnt_t frame_words,
	output s2mm_pkg::axi_addr_t  burst_addr,
	output logic                 last_beat,
	output logic                 frame_done
);
	// Bytes covered by one full burst
	localparam int BURST_BYTES = `S2MM_BURST_LEN * (`S2MM_DATA_W / 8);

	s2mm_pkg::beat_cnt_t  beat_cnt;
	s2mm_pkg::frame_cnt_t word_cnt;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			beat_cnt <= '0;
			word_cnt <= '0;
		end
		else if (frame_start)
		begin
			beat_cnt <= '0;
			word_cnt <= '0;
		end
		else
		begin
			if (burst_done)
				beat_cnt <= '0;
			else if (beat)
				beat_cnt <= beat_cnt + 1'b1;
			if (beat)
				word_cnt <= word_cnt + 1'b1;
		end
	end

	// Address of the burst being issued
	always_ff @(posedge clk)
	begin
		if (frame_start)
			burst_addr <= base_addr;
		else if (burst_done)
			burst_addr <= burst_addr + s2mm_pkg::axi_addr_t'(BURST_BYTES);
	end

	assign last_beat = (beat_cnt == s2mm_pkg::beat_cnt_t'(`S2MM_BURST_LEN - 1));
	assign frame_done = (word_cnt == frame_words);

	// A burst never runs past 16 beats
	a_no_beat_past_last: assert property (@(posedge clk) disable iff (rst)
		(beat && last_beat) |=> (!beat until burst_done))
		else $error("beat after last_beat before burst_done");

endmodule

`default_nettype wire

/* frame_writer_fsm.sv */
`default_nettype none

`include "s2mm_defines.svh"

module frame_writer_fsm
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      soft_rst,
	input  logic                      empty,
	input  logic                      word_sof,
	input  logic [`S2MM_CNT_BITS-1:0] rd_data_count,
	input  logic                      last_beat,
	input  logic                      frame_done,
	input  logic                      awready,
	input  logic                      wready,
	input  logic                      bvalid,
	output logic                      awvalid,
	output logic                      wvalid,
	output logic                      wlast,
	output logic                      bready,
	output logic                      rd_en,
	output logic                      flush,
	output logic                      frame_start,
	output logic                      beat,
	output logic                      burst_done,
	output logic                      resetting,
	output logic                      s2mm_sof
);
	s2mm_pkg::wr_state_e state;
	s2mm_pkg::wr_state_e state_nx;

	logic pending;
	logic sync_look;

	////////////////////
	// Next state

	always_comb
	begin
		state_nx = state;
		case (state)
			s2mm_pkg::WR_IDLE:
				state_nx = s2mm_pkg::WR_SYNC;
			s2mm_pkg::WR_SYNC:
				if (pending)
					state_nx = s2mm_pkg::WR_FLUSH;
				else if (!empty && word_sof)
					state_nx = s2mm_pkg::WR_ADDR;
			s2mm_pkg::WR_ADDR:
				if (awvalid && awready)
					state_nx = s2mm_pkg::WR_DATA;
				else if (!awvalid && pending)
					state_nx = s2mm_pkg::WR_FLUSH;
			s2mm_pkg::WR_DATA:
				if (beat && last_beat)
					state_nx = s2mm_pkg::WR_RESP;
			s2mm_pkg::WR_RESP:
				if (bvalid)
				begin
					if (pending)
						state_nx = s2mm_pkg::WR_FLUSH;
					else if (frame_done)
						state_nx = s2mm_pkg::WR_SYNC;
					else
						state_nx = s2mm_pkg::WR_ADDR;
				end
			s2mm_pkg::WR_FLUSH:
				state_nx = s2mm_pkg::WR_SYNC;
			default:
				state_nx = s2mm_pkg::WR_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state   <= s2mm_pkg::WR_IDLE;
			pending <= 1'b0;
		end
		else
		begin
			state <= state_nx;
			// Held through the FLUSH cycle, dropped after it
			pending <= soft_rst | (pending & (state != s2mm_pkg::WR_FLUSH));
		end
	end

	assign resetting = pending;

	////////////////////
	// Outputs

	// Head word is inspected while hunting for start of frame
	assign sync_look = (state == s2mm_pkg::WR_SYNC) && !pending && !empty;

	assign s2mm_sof = sync_look && word_sof;
	assign frame_start = s2mm_sof;

	// Enough data for a whole burst before the address goes out
	assign awvalid = (state == s2mm_pkg::WR_ADDR) && (rd_data_count >= `S2MM_BURST_LEN);

	assign wvalid = (state == s2mm_pkg::WR_DATA) && !empty;
	assign wlast = (state == s2mm_pkg::WR_DATA) && last_beat;
	assign beat = wvalid && wready;

	assign bready = (state == s2mm_pkg::WR_RESP);
	assign burst_done = bready && bvalid;

	// Discard stale words, or consume one per data beat
	assign rd_en = (sync_look && !word_sof) || beat;
	assign flush = (state == s2mm_pkg::WR_FLUSH);

	a_aw_held: assert property (@(posedge clk) disable iff (rst)
		(awvalid && !awready) |=> awvalid)
		else $error("awvalid dropped before awready");

endmodule

`default_nettype wire

/* s2mm.sv */
`default_nettype none

`include "s2mm_defines.svh"

module s2mm
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic [`S2MM_IMG_BITS-1:0] img_width,
	input  logic [`S2MM_IMG_BITS-1:0] img_height,
	input  logic                     soft_rst,
	output logic                     resetting,
	input  logic                     s_axis_tvalid,
	input  s2mm_pkg::pixel_t         s_axis_tdata,
	input  logic                     s_axis_tuser,
	input  logic                     s_axis_tlast,
	output logic                     s_axis_tready,
	input  logic                     fifo_full,
	output logic                     fifo_wr_en,
	output s2mm_pkg::tagged_pixel_t  fifo_wr_data,
	output logic                     s2mm_sof,
	input  s2mm_pkg::axi_addr_t      s2mm_addr,
	fifo_rd_if.reader                rd,
	axi_wr_if.master                 axi
);
	localparam int LANES = `S2MM_PIX_PER_WORD;
	localparam int PW = `S2MM_PIXEL_W;

	logic [2*`S2MM_IMG_BITS-1:0] frame_pixels;
	s2mm_pkg::frame_cnt_t frame_words;
	s2mm_pkg::axi_data_t pixel_data;
	logic [LANES-2:0] early_eol;
	logic frame_start;
	logic beat;
	logic burst_done;
	logic last_beat;
	logic frame_done;

	////////////////////
	// Stream into FIFO
	assign s_axis_tready = ~fifo_full;
	assign fifo_wr_en = s_axis_tvalid & s_axis_tready;
	assign fifo_wr_data = '{eol: s_axis_tlast, sof: s_axis_tuser, pix: s_axis_tdata};

	assign frame_pixels = img_width * img_height;
	assign frame_words = frame_pixels[2*`S2MM_IMG_BITS-1:$clog2(LANES)];

	////////////////////
	// FIFO word to AXI beat

	// Lane reversal puts the first pixel in the low byte
	always_comb
	begin
		for (int i = 0; i < LANES; i++)
			pixel_data[i*PW +: PW] = rd.rd_data[LANES-1-i].pix;
	end

	// eol of every pixel but the last in the word
	always_comb
	begin
		for (int i = 0; i < LANES-1; i++)
			early_eol[i] = rd.rd_data[LANES-1-i].eol;
	end

	assign axi.wdata = pixel_data;
	assign axi.wstrb = '1;
	assign axi.awlen = 8'(`S2MM_BURST_LEN - 1);
	assign axi.awsize = 3'($clog2(`S2MM_DATA_W / 8));
	// INCR
	assign axi.awburst = 2'b01;
	assign axi.awlock = 1'b0;
	assign axi.awcache = '0;
	assign axi.awprot = '0;
	assign axi.awqos = '0;

	frame_writer_fsm u_fsm
	(
		.clk(clk),
		.rst(rst),
		.soft_rst(soft_rst),
		.empty(rd.empty),
		.word_sof(rd.rd_data[LANES-1].sof),
		.rd_data_count(rd.rd_data_count),
		.last_beat(last_beat),
		.frame_done(frame_done),
		.awready(axi.awready),
		.wready(axi.wready),
		.bvalid(axi.bvalid),
		.awvalid(axi.awvalid),
		.wvalid(axi.wvalid),
		.wlast(axi.wlast),
		.bready(axi.bready),
		.rd_en(rd.rd_en),
		.flush(rd.flush),
		.frame_start(frame_start),
		.beat(beat),
		.burst_done(burst_done),
		.resetting(resetting),
		.s2mm_sof(s2mm_sof)
	);

	burst_counter u_cnt
	(
		.clk(clk),
		.rst(rst),
		.frame_start(frame_start),
		.beat(beat),
		.burst_done(burst_done),
		.base_addr(s2mm_addr),
		.frame_words(frame_words),
		.burst_addr(axi.awaddr),
		.last_beat(last_beat),
		.frame_done(frame_done)
	);

	// Width is a multiple of 4, so lines end on a word boundary
	a_eol_word_end: assert property (@(posedge clk) disable iff (rst)
		!rd.empty |-> (early_eol == '0))
		else $error("line end inside a FIFO word");

endmodule

`default_nettype wire

/* s2mm_top.sv */
`default_nettype none

`include "s2mm_defines.svh"

module s2mm_top
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic [`S2MM_IMG_BITS-1:0]  img_width,
	input  logic [`S2MM_IMG_BITS-1:0]  img_height,
	input  logic                       soft_rst,
	output logic                       resetting,
	input  logic                       s_axis_tvalid,
	input  logic [`S2MM_PIXEL_W-1:0]   s_axis_tdata,
	input  logic                       s_axis_tuser,
	input  logic                       s_axis_tlast,
	output logic                       s_axis_tready,
	output logic                       s2mm_sof,
	input  logic [`S2MM_ADDR_W-1:0]    s2mm_addr,
	output logic [`S2MM_ADDR_W-1:0]    m_axi_awaddr,
	output logic [7:0]                 m_axi_awlen,
	output logic [2:0]                 m_axi_awsize,
	output logic [1:0]                 m_axi_awburst,
	output logic                       m_axi_awlock,
	output logic [3:0]                 m_axi_awcache,
	output logic [2:0]                 m_axi_awprot,
	output logic [3:0]                 m_axi_awqos,
	output logic                       m_axi_awvalid,
	input  logic                       m_axi_awready,
	output logic [`S2MM_DATA_W-1:0]    m_axi_wdata,
	output logic [`S2MM_DATA_W/8-1:0]  m_axi_wstrb,
	output logic                       m_axi_wlast,
	output logic                       m_axi_wvalid,
	input  logic                       m_axi_wready,
	input  logic                       m_axi_bvalid,
	output logic                       m_axi_bready
);
	fifo_rd_if rd_bus ();
	axi_wr_if  axi_bus ();

	logic fifo_full;
	logic fifo_wr_en;
	s2mm_pkg::tagged_pixel_t fifo_wr_data;

	pixel_fifo u_fifo
	(
		.clk(clk),
		.rst(rst),
		.wr_en(fifo_wr_en),
		.wr_data(fifo_wr_data),
		.full(fifo_full),
		.rd(rd_bus.fifo)
	);

	s2mm u_s2mm
	(
		.clk(clk),
		.rst(rst),
		.img_width(img_width),
		.img_height(img_height),
		.soft_rst(soft_rst),
		.resetting(resetting),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tuser(s_axis_tuser),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tready(s_axis_tready),
		.fifo_full(fifo_full),
		.fifo_wr_en(fifo_wr_en),
		.fifo_wr_data(fifo_wr_data),
		.s2mm_sof(s2mm_sof),
		.s2mm_addr(s2mm_addr),
		.rd(rd_bus.reader),
		.axi(axi_bus.master)
	);

	////////////////////
	// AXI bus out to pins
	assign m_axi_awaddr  = axi_bus.awaddr;
	assign m_axi_awlen   = axi_bus.awlen;
	assign m_axi_awsize  = axi_bus.awsize;
	assign m_axi_awburst = axi_bus.awburst;
	assign m_axi_awlock  = axi_bus.awlock;
	assign m_axi_awcache = axi_bus.awcache;
	assign m_axi_awprot  = axi_bus.awprot;
	assign m_axi_awqos   = axi_bus.awqos;
	assign m_axi_awvalid = axi_bus.awvalid;
	assign m_axi_wdata   = axi_bus.wdata;
	assign m_axi_wstrb   = axi_bus.wstrb;
	assign m_axi_wlast   = axi_bus.wlast;
	assign m_axi_wvalid  = axi_bus.wvalid;
	assign m_axi_bready  = axi_bus.bready;

	assign axi_bus.awready = m_axi_awready;
	assign axi_bus.wready  = m_axi_wready;
	assign axi_bus.bvalid  = m_axi_bvalid;

endmodule

`default_nettype wire

/* tb_s2mm.sv */
`default_nettype none

`include "s2mm_defines.svh"

module tb_s2mm;
	timeunit 1ns;
	timeprecision 1ps;

	// Junk, 16x8, two 32x4, 32x32, aborted 80 pixels, fresh 32x4
	localparam int TOTAL_PIXELS = 8 + 16*8 + 2*32*4 + 32*32 + 80 + 32*4;
	localparam int TIMEOUT_CYCLES = 4*TOTAL_PIXELS + 2000;
	localparam int BURST_BYTES = `S2MM_BURST_LEN * `S2MM_DATA_W / 8;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic [`S2MM_IMG_BITS-1:0] img_width = '0;
	logic [`S2MM_IMG_BITS-1:0] img_height = '0;
	logic soft_rst = 1'b0;
	logic resetting;
	logic s_axis_tvalid = 1'b0;
	s2mm_pkg::pixel_t s_axis_tdata = '0;
	logic s_axis_tuser = 1'b0;
	logic s_axis_tlast = 1'b0;
	logic s_axis_tready;
	logic s2mm_sof;
	s2mm_pkg::axi_addr_t s2mm_addr = '0;
	s2mm_pkg::axi_addr_t m_axi_awaddr;
	logic [7:0] m_axi_awlen;
	logic [2:0] m_axi_awsize;
	logic [1:0] m_axi_awburst;
	logic m_axi_awlock;
	logic [3:0] m_axi_awcache;
	logic [2:0] m_axi_awprot;
	logic [3:0] m_axi_awqos;
	logic m_axi_awvalid;
	logic m_axi_awready = 1'b0;
	s2mm_pkg::axi_data_t m_axi_wdata;
	logic [`S2MM_DATA_W/8-1:0] m_axi_wstrb;
	logic m_axi_wlast;
	logic m_axi_wvalid;
	logic m_axi_wready = 1'b0;
	logic m_axi_bvalid = 1'b0;
	logic m_axi_bready;

	integer seed = 18;
	int cycle = 0;
	int mismatch_count = 0;
	int fail_count = 0;
	int sof_count = 0;
	int aw_count = 0;
	int bursts_done = 0;
	int beat_idx = 0;
	int mark_aw = 0;
	int mark_sof = 0;
	int mark_b = 0;
	logic b_due = 1'b0;
	logic hold_w = 1'b0;
	logic stalled = 1'b0;
	logic prev_sof = 1'b0;
	s2mm_pkg::axi_addr_t next_addr = '0;
	s2mm_pkg::axi_addr_t burst_addr = '0;
	s2mm_pkg::axi_addr_t base_q [$];
	s2mm_pkg::axi_data_t mem [s2mm_pkg::axi_addr_t];

	s2mm_top s2mm_top_i (.*);

	initial
	begin
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle == TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	////////////////////
	// Expected word, first pixel in the low byte
	function automatic s2mm_pkg::axi_data_t ref_word(input int fnum, input int widx);
		s2mm_pkg::axi_data_t w;
		for (int lane = 0; lane < `S2MM_PIX_PER_WORD; lane++)
			w[lane*8 +: 8] = 8'((fnum + widx*`S2MM_PIX_PER_WORD + lane) % 256);
		return w;
	endfunction

	task automatic check_data(input string name, input s2mm_pkg::axi_data_t exp,
		input s2mm_pkg::axi_data_t act);
		if (exp !== act)
		begin
			mismatch_count++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input s2mm_pkg::axi_addr_t exp,
		input s2mm_pkg::axi_addr_t act);
		if (exp !== act)
		begin
			mismatch_count++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act)
		begin
			mismatch_count++;
			$display("mismatch %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	////////////////////
	// AXI slave, readies change on the rising edge
	always @(posedge clk)
	begin
		if (rst)
		begin
			m_axi_awready <= 1'b0;
			m_axi_wready <= 1'b0;
			m_axi_bvalid <= 1'b0;
		end
		else
		begin
			m_axi_awready <= ($random(seed) & 3) != 0;
			// Long stretches of wready low under back-pressure
			if (hold_w)
				m_axi_wready <= (cycle % 256 >= 192) && (($random(seed) & 3) != 0);
			else
				m_axi_wready <= ($random(seed) & 3) != 0;
			m_axi_bvalid <= b_due;
		end
	end

	// Handshakes seen here complete at the next rising edge
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (s2mm_sof && prev_sof)
			begin
				fail_count++;
				$display("s2mm_sof stayed high for more than one cycle");
			end
			if (s2mm_sof)
			begin
				sof_count++;
				if (base_q.size() == 0)
				begin
					fail_count++;
					$display("s2mm_sof pulsed with no frame being sent");
				end
				else
					next_addr = base_q.pop_front();
			end
			if (m_axi_awvalid && m_axi_awready)
			begin
				check_count("awlen", `S2MM_BURST_LEN - 1, m_axi_awlen);
				check_count("awsize", 2, m_axi_awsize);
				check_count("awburst", 1, m_axi_awburst);
				check_count("other AW fields", 0,
					{m_axi_awlock, m_axi_awcache, m_axi_awprot, m_axi_awqos});
				check_addr("awaddr", next_addr, m_axi_awaddr);
				burst_addr = m_axi_awaddr;
				next_addr = next_addr + BURST_BYTES;
				beat_idx = 0;
				aw_count++;
			end
			if (m_axi_wvalid && m_axi_wready)
			begin
				mem[burst_addr + 4*beat_idx] = m_axi_wdata;
				check_count("wstrb", 15, m_axi_wstrb);
				check_count("wlast", beat_idx == `S2MM_BURST_LEN - 1, m_axi_wlast);
				beat_idx++;
				if (beat_idx == `S2MM_BURST_LEN)
					b_due = 1'b1;
			end
			if (m_axi_bvalid && m_axi_bready)
			begin
				b_due = 1'b0;
				bursts_done++;
			end
			if (s_axis_tvalid && !s_axis_tready)
				stalled = 1'b1;
			prev_sof = s2mm_sof;
		end
	end

	////////////////////
	// Stream side, called on a rising edge
	task automatic stream_pixel(input s2mm_pkg::pixel_t pix, input logic user, input logic last);
		s_axis_tvalid <= 1'b1;
		s_axis_tdata <= pix;
		s_axis_tuser <= user;
		s_axis_tlast <= last;
		@(negedge clk);
		while (!s_axis_tready)
			@(negedge clk);
		@(posedge clk);
	endtask

	task automatic send_frame(input int fnum, input int width, input int height,
		input s2mm_pkg::axi_addr_t base, input int junk, input int count);
		int p;
		base_q.push_back(base);
		img_width <= width[`S2MM_IMG_BITS-1:0];
		img_height <= height[`S2MM_IMG_BITS-1:0];
		s2mm_addr <= base;
		for (p = 0; p < junk; p++)
			stream_pixel(8'(8'hc3 ^ p), 1'b0, 1'b0);
		for (p = 0; p < count; p++)
			stream_pixel(8'((fnum + p) % 256), p == 0, (p % width) == width - 1);
		s_axis_tvalid <= 1'b0;
		s_axis_tuser <= 1'b0;
		s_axis_tlast <= 1'b0;
	endtask

	task automatic mark_counts();
		mark_aw = aw_count;
		mark_sof = sof_count;
		mark_b = bursts_done;
	endtask

	task automatic wait_frames(input int bursts, input int frames);
		while (bursts_done < mark_b + bursts)
			@(negedge clk);
		check_count("bursts", bursts, aw_count - mark_aw);
		check_count("s2mm_sof pulses", frames, sof_count - mark_sof);
		@(posedge clk);
	endtask

	task automatic verify_frame(input int fnum, input s2mm_pkg::axi_addr_t base, input int words);
		s2mm_pkg::axi_addr_t addr;
		for (int w = 0; w < words; w++)
		begin
			addr = base + 4*w;
			if (!mem.exists(addr))
			begin
				fail_count++;
				$display("word %0d of frame %0d was never written", w, fnum);
			end
			else
				check_data($sformatf("frame %0d word %0d", fnum, w), ref_word(fnum, w), mem[addr]);
		end
	endtask

	initial
	begin
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// Junk ahead of the first tuser must never reach memory
		mark_counts();
		send_frame(1, 16, 8, 32'h1000, 8, 16*8);
		wait_frames(2, 1);
		verify_frame(1, 32'h1000, 32);

		// Two frames back to back, each with its own base
		mark_counts();
		send_frame(3, 32, 4, 32'h2000, 0, 32*4);
		send_frame(4, 32, 4, 32'h3000, 0, 32*4);
		wait_frames(4, 2);
		verify_frame(3, 32'h2000, 32);
		verify_frame(4, 32'h3000, 32);

		// Back-pressure fills the FIFO
		mark_counts();
		hold_w <= 1'b1;
		stalled = 1'b0;
		send_frame(7, 32, 32, 32'h8000, 0, 32*32);
		wait_frames(16, 1);
		hold_w <= 1'b0;
		if (!stalled)
		begin
			fail_count++;
			$display("tready never fell while wready was held low");
		end
		verify_frame(7, 32'h8000, 256);

		// Soft reset part way through a frame
		send_frame(5, 32, 4, 32'h4000, 0, 80);
		soft_rst <= 1'b1;
		@(posedge clk);
		soft_rst <= 1'b0;
		@(negedge clk);
		if (!resetting)
		begin
			fail_count++;
			$display("resetting did not rise after soft_rst");
		end
		while (resetting)
			@(negedge clk);
		@(posedge clk);
		mark_counts();
		send_frame(6, 32, 4, 32'h5000, 0, 32*4);
		wait_frames(2, 1);
		verify_frame(6, 32'h5000, 32);

		$display("checks done: %0d mismatches, %0d other errors", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
s2mm_pkg.sv
s2mm_ifs.sv
pixel_fifo.sv
burst_counter.sv
frame_writer_fsm.sv
s2mm.sv
s2mm_top.sv
tb_s2mm.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_s2mm -o tb_s2mm \
	&& ./obj_dir/tb_s2mm > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^=== PASS ===$" sim.log && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }
